//--- design/axi_bus_pkg.sv
package axi_bus_pkg;

    // bus field widths
    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;
    typedef logic [3:0]  id_t;
    typedef logic [3:0]  len_t;
    typedef logic [2:0]  size_t;
    typedef logic [1:0]  burst_t;
    typedef logic [1:0]  resp_t;

    // index into the byte storage
    typedef logic [6:0]  mem_idx_t;

    localparam int MEM_BYTES = 128;

    // largest size code served, 4 bytes per beat
    localparam size_t MAX_SIZE = 3'd2;

    // burst kinds, code 2 falls through to incr
    localparam burst_t BURST_FIXED = 2'd0;
    localparam burst_t BURST_INCR  = 2'd1;

    localparam resp_t RESP_OKAY   = 2'd0;
    localparam resp_t RESP_SLVERR = 2'd2;
    localparam resp_t RESP_DECERR = 2'd3;

endpackage

//--- design/slave_state_pkg.sv
package slave_state_pkg;

    // write side, one request at a time
    typedef enum logic [1:0] {
        wr_idle,
        wr_addr,
        wr_data,
        wr_resp
    } wr_state_t;

    // read side, err returns the single error beat
    typedef enum logic [1:0] {
        rd_idle,
        rd_addr,
        rd_data,
        rd_err
    } rd_state_t;

endpackage

//--- design/slave_ifs.sv
// sequencer to beat generator
interface beat_if;
    import axi_bus_pkg::*;

    logic       load;
    addr_t      addr_start;
    len_t       len;
    logic       fixed;
    // bytes to advance, 1 to 4
    logic [2:0] step_bytes;
    logic       step;
    addr_t      addr;
    logic       last;

    modport ctrl (
        output load, addr_start, len, fixed, step_bytes, step,
        input  addr, last
    );

    modport gen (
        input  load, addr_start, len, fixed, step_bytes, step,
        output addr, last
    );

endinterface

// write port into the byte storage
interface mem_wr_if;
    import axi_bus_pkg::*;

    logic  en;
    addr_t addr;
    data_t data;
    strb_t strb;

    modport src (
        output en, addr, data, strb
    );

    modport mem (
        input  en, addr, data, strb
    );

endinterface

//--- design/burst_ctrl.sv
module burst_ctrl (
    input  logic                 clk,
    input  logic                 resetn,

    input  logic                 awvalid,
    input  axi_bus_pkg::id_t     awid,
    input  axi_bus_pkg::addr_t   awaddr,
    input  axi_bus_pkg::len_t    awlen,
    input  axi_bus_pkg::size_t   awsize,
    input  axi_bus_pkg::burst_t  awburst,
    output logic                 awready,

    input  logic                 wvalid,
    input  axi_bus_pkg::strb_t   wstrb,
    output logic                 wready,

    input  logic                 bready,
    output logic                 bvalid,
    output axi_bus_pkg::id_t     bid,
    output axi_bus_pkg::resp_t   bresp,

    input  logic                 arvalid,
    input  axi_bus_pkg::id_t     arid,
    input  axi_bus_pkg::addr_t   araddr,
    input  axi_bus_pkg::len_t    arlen,
    input  axi_bus_pkg::size_t   arsize,
    input  axi_bus_pkg::burst_t  arburst,
    output logic                 arready,

    input  logic                 rready,
    output logic                 rvalid,
    output logic                 rlast,
    output axi_bus_pkg::id_t     rid,
    output axi_bus_pkg::resp_t   rresp,
    output axi_bus_pkg::size_t   rd_size,

    beat_if.ctrl                 wr_beat,
    beat_if.ctrl                 rd_beat,
    mem_wr_if.src                mem_wr
);
    import axi_bus_pkg::*;
    import slave_state_pkg::*;

    wr_state_t wr_state;
    id_t       wr_id_q;
    len_t      wr_len_q;
    logic      wr_fixed_q;
    resp_t     wr_resp_q;

    rd_state_t rd_state;
    id_t       rd_id_q;
    len_t      rd_len_q;
    logic      rd_fixed_q;
    size_t     rd_size_q;
    resp_t     rd_resp_q;

    // out of range address first, then unsupported size
    function automatic resp_t req_resp(addr_t addr, size_t size);
        if (addr >= MEM_BYTES)
            return RESP_SLVERR;
        if (size > MAX_SIZE)
            return RESP_DECERR;
        return RESP_OKAY;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // write channel

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle: if (awvalid) wr_state <= wr_addr;
                wr_addr: wr_state <= wr_data;
                wr_data: if (wvalid && wr_beat.last) wr_state <= wr_resp;
                wr_resp: if (bready) wr_state <= wr_idle;
                default: wr_state <= wr_idle;
            endcase
        end
    end

    // request fields taken in the awready cycle
    always_ff @(posedge clk) begin
        if (wr_state == wr_addr) begin
            wr_id_q    <= awid;
            wr_len_q   <= awlen;
            wr_fixed_q <= (awburst == BURST_FIXED);
            wr_resp_q  <= req_resp(awaddr, awsize);
        end
    end

    assign awready = (wr_state == wr_addr);
    assign wready  = (wr_state == wr_data);
    assign bvalid  = (wr_state == wr_resp);
    assign bid     = wr_id_q;
    assign bresp   = wr_resp_q;

    assign wr_beat.load       = awready;
    assign wr_beat.addr_start = awaddr;
    assign wr_beat.len        = wr_len_q;
    assign wr_beat.fixed      = wr_fixed_q;
    // packed lanes, so advance by enabled strobes
    assign wr_beat.step_bytes = 3'($countones(wstrb));
    assign wr_beat.step       = wready && wvalid;

    // failed bursts still consume their beats
    assign mem_wr.en = wr_beat.step && (wr_resp_q == RESP_OKAY);

    ////////////////////////////////////////////////////////////////////////////
    // read channel

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle: if (arvalid) rd_state <= rd_addr;
                rd_addr: begin
                    if (req_resp(araddr, arsize) == RESP_OKAY)
                        rd_state <= rd_data;
                    else
                        rd_state <= rd_err;
                end
                rd_data: if (rready && rd_beat.last) rd_state <= rd_idle;
                rd_err:  if (rready) rd_state <= rd_idle;
                default: rd_state <= rd_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rd_state == rd_addr) begin
            rd_id_q    <= arid;
            rd_len_q   <= arlen;
            rd_fixed_q <= (arburst == BURST_FIXED);
            rd_size_q  <= arsize;
            rd_resp_q  <= req_resp(araddr, arsize);
        end
    end

    assign arready = (rd_state == rd_addr);
    assign rvalid  = (rd_state == rd_data) || (rd_state == rd_err);
    assign rlast   = (rd_state == rd_err) || ((rd_state == rd_data) && rd_beat.last);
    assign rid     = rd_id_q;
    assign rresp   = rd_resp_q;

    // a code above MAX_SIZE makes the memory return zero
    assign rd_size = (rd_state == rd_data) ? rd_size_q : size_t'(MAX_SIZE + 1);

    assign rd_beat.load       = arready;
    assign rd_beat.addr_start = araddr;
    assign rd_beat.len        = rd_len_q;
    assign rd_beat.fixed      = rd_fixed_q;
    assign rd_beat.step_bytes = 3'd1 << rd_size_q;
    assign rd_beat.step       = (rd_state == rd_data) && rready;

endmodule

//--- design/beat_addr_gen.sv
module beat_addr_gen (
    input  logic clk,
    input  logic resetn,
    beat_if.gen  beat
);
    import axi_bus_pkg::*;

    len_t  beat_cnt;
    addr_t beat_addr;

    // beats accepted so far in this burst
    always_ff @(posedge clk) begin
        if (!resetn) begin
            beat_cnt <= '0;
        end else if (beat.load) begin
            beat_cnt <= '0;
        end else if (beat.step) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // fixed bursts hold the start address
    always_ff @(posedge clk) begin
        if (beat.load) begin
            beat_addr <= beat.addr_start;
        end else if (beat.step && !beat.fixed) begin
            beat_addr <= beat_addr + addr_t'(beat.step_bytes);
        end
    end

    assign beat.addr = beat_addr;
    assign beat.last = (beat_cnt == beat.len);

endmodule

//--- design/byte_mem.sv
module byte_mem (
    input  logic               clk,
    input  logic               resetn,
    mem_wr_if.mem              wr,
    input  axi_bus_pkg::addr_t rd_addr,
    input  axi_bus_pkg::size_t rd_size,
    output axi_bus_pkg::data_t rd_data
);
    import axi_bus_pkg::*;

    logic [7:0] mem [MEM_BYTES];

    mem_idx_t   wr_idx;
    mem_idx_t   rd_idx;
    logic [7:0] pack_byte [4];
    logic [3:0] pack_en;
    logic [7:0] rd_byte [4];

    assign wr_idx = wr.addr[6:0];
    assign rd_idx = rd_addr[6:0];

    // squeeze enabled lanes down to the low slots, lane 0 first
    always_comb begin
        logic [2:0] n;
        n = '0;
        pack_en = '0;
        for (int k = 0; k < 4; k++) begin
            pack_byte[k] = '0;
        end
        for (int lane = 0; lane < 4; lane++) begin
            if (wr.strb[lane]) begin
                pack_byte[n[1:0]] = wr.data[8*lane +: 8];
                pack_en[n[1:0]]   = 1'b1;
                n = n + 3'd1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // storage, reset loads each byte with its own index

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int i = 0; i < MEM_BYTES; i++) begin
                mem[i] <= 8'(i);
            end
        end else if (wr.en) begin
            for (int k = 0; k < 4; k++) begin
                if (pack_en[k])
                    mem[wr_idx + mem_idx_t'(k)] <= pack_byte[k];
            end
        end
    end

    // consecutive bytes, index wraps at the top of memory
    always_comb begin
        for (int k = 0; k < 4; k++) begin
            rd_byte[k] = mem[rd_idx + mem_idx_t'(k)];
        end
    end

    always_comb begin
        case (rd_size)
            3'd0:    rd_data = {24'h0, rd_byte[0]};
            3'd1:    rd_data = {16'h0, rd_byte[1], rd_byte[0]};
            3'd2:    rd_data = {rd_byte[3], rd_byte[2], rd_byte[1], rd_byte[0]};
            default: rd_data = '0;
        endcase
    end

endmodule

//--- design/axi_mem_slave.sv
module axi_mem_slave (
    input  logic                 clk,
    input  logic                 resetn,

    input  logic                 awvalid,
    input  axi_bus_pkg::id_t     awid,
    input  axi_bus_pkg::addr_t   awaddr,
    input  axi_bus_pkg::len_t    awlen,
    input  axi_bus_pkg::size_t   awsize,
    input  axi_bus_pkg::burst_t  awburst,
    output logic                 awready,

    input  logic                 wvalid,
    input  axi_bus_pkg::data_t   wdata,
    input  axi_bus_pkg::id_t     wid,
    input  axi_bus_pkg::strb_t   wstrb,
    input  logic                 wlast,
    output logic                 wready,

    input  logic                 bready,
    output logic                 bvalid,
    output axi_bus_pkg::resp_t   bresp,
    output axi_bus_pkg::id_t     bid,

    input  logic                 arvalid,
    input  axi_bus_pkg::id_t     arid,
    input  axi_bus_pkg::addr_t   araddr,
    input  axi_bus_pkg::len_t    arlen,
    input  axi_bus_pkg::size_t   arsize,
    input  axi_bus_pkg::burst_t  arburst,
    output logic                 arready,

    input  logic                 rready,
    output logic                 rvalid,
    output axi_bus_pkg::data_t   rdata,
    output logic                 rlast,
    output axi_bus_pkg::resp_t   rresp,
    output axi_bus_pkg::id_t     rid
);

    // wid and wlast stay unconnected, the beat counter closes each burst

    axi_bus_pkg::size_t rd_size;

    beat_if   wr_beat ();
    beat_if   rd_beat ();
    mem_wr_if mem_wr ();

    // write port fed straight from the bus and the write generator
    assign mem_wr.addr = wr_beat.addr;
    assign mem_wr.data = wdata;
    assign mem_wr.strb = wstrb;

    burst_ctrl ctrl (
        .clk     (clk),
        .resetn  (resetn),
        .awvalid (awvalid),
        .awid    (awid),
        .awaddr  (awaddr),
        .awlen   (awlen),
        .awsize  (awsize),
        .awburst (awburst),
        .awready (awready),
        .wvalid  (wvalid),
        .wstrb   (wstrb),
        .wready  (wready),
        .bready  (bready),
        .bvalid  (bvalid),
        .bid     (bid),
        .bresp   (bresp),
        .arvalid (arvalid),
        .arid    (arid),
        .araddr  (araddr),
        .arlen   (arlen),
        .arsize  (arsize),
        .arburst (arburst),
        .arready (arready),
        .rready  (rready),
        .rvalid  (rvalid),
        .rlast   (rlast),
        .rid     (rid),
        .rresp   (rresp),
        .rd_size (rd_size),
        .wr_beat (wr_beat.ctrl),
        .rd_beat (rd_beat.ctrl),
        .mem_wr  (mem_wr.src)
    );

    beat_addr_gen wr_gen (
        .clk    (clk),
        .resetn (resetn),
        .beat   (wr_beat.gen)
    );

    beat_addr_gen rd_gen (
        .clk    (clk),
        .resetn (resetn),
        .beat   (rd_beat.gen)
    );

    // error beats read as zero through the size code
    byte_mem mem (
        .clk     (clk),
        .resetn  (resetn),
        .wr      (mem_wr.mem),
        .rd_addr (rd_beat.addr),
        .rd_size (rd_size),
        .rd_data (rdata)
    );

endmodule

//--- bench/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held across the first three rising edges
    initial begin
        resetn = 1'b0;
        repeat (3) @(posedge clk);
        resetn <= 1'b1;
    end

endmodule

//--- bench/tb_axi_mem_slave.sv
module tb_axi_mem_slave;
    import axi_bus_pkg::*;

    logic clk, resetn;
    logic awvalid, awready, wvalid, wready, wlast, bready, bvalid;
    logic arvalid, arready, rready, rvalid, rlast;
    id_t awid, wid, bid, arid, rid;
    addr_t awaddr, araddr;
    len_t awlen, arlen;
    size_t awsize, arsize;
    burst_t awburst, arburst;
    data_t wdata, rdata;
    strb_t wstrb;
    resp_t bresp, rresp;

    // reference copy of the byte storage
    logic [7:0] model [MEM_BYTES];
    int checks;
    int errors;

    tb_clk_gen clk_gen (.clk(clk), .resetn(resetn));

    axi_mem_slave axi_mem_slave_i (
        .clk(clk), .resetn(resetn),
        .awvalid(awvalid), .awid(awid), .awaddr(awaddr), .awlen(awlen),
        .awsize(awsize), .awburst(awburst), .awready(awready),
        .wvalid(wvalid), .wdata(wdata), .wid(wid), .wstrb(wstrb), .wlast(wlast),
        .wready(wready),
        .bready(bready), .bvalid(bvalid), .bresp(bresp), .bid(bid),
        .arvalid(arvalid), .arid(arid), .araddr(araddr), .arlen(arlen),
        .arsize(arsize), .arburst(arburst), .arready(arready),
        .rready(rready), .rvalid(rvalid), .rdata(rdata), .rlast(rlast),
        .rresp(rresp), .rid(rid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // checking and waiting

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            $display("FAIL at %0t: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    task automatic stop_on_timeout(input string name);
        $display("timeout: %s stayed low for 50 cycles", name);
        $display("checks: %0d, errors: %0d, timeouts: 1", checks, errors);
        $display("Some tests failed");
        $finish;
    endtask

    function automatic logic level_of(input string name);
        case (name)
            "resetn":  return resetn;
            "awready": return awready;
            "wready":  return wready;
            "bvalid":  return bvalid;
            "arready": return arready;
            "rvalid":  return rvalid;
            default:   return 1'b0;
        endcase
    endfunction

    // polls on falling edges until the level is high or 50 cycles pass
    task automatic wait_for(input string name);
        int cnt;
        cnt = 0;
        while (!level_of(name) && cnt < 50) begin
            @(negedge clk);
            cnt++;
        end
        if (!level_of(name))
            stop_on_timeout(name);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // reference model

    // enabled lanes land lowest first in consecutive bytes
    function automatic int model_write(input addr_t addr, input data_t data, input strb_t strb);
        int n;
        n = 0;
        for (int lane = 0; lane < 4; lane++) begin
            if (strb[lane]) begin
                model[(addr + n) % MEM_BYTES] = data[8*lane +: 8];
                n++;
            end
        end
        return n;
    endfunction

    function automatic data_t model_word(input addr_t addr, input size_t size);
        data_t word;
        word = '0;
        for (int k = 0; k < (1 << size); k++)
            word[8*k +: 8] = model[(addr + k) % MEM_BYTES];
        return word;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // bus transactions

    task automatic do_write(input id_t id, input addr_t addr, input len_t len, input size_t size,
                            input burst_t burst, input resp_t exp_resp, output int total);
        addr_t beat_addr;
        data_t data;
        strb_t strb;
        int n;
        int delay;
        beat_addr = addr;
        total = 0;
        awvalid = 1'b1;
        awid = id;
        awaddr = addr;
        awlen = len;
        awsize = size;
        awburst = burst;
        wait_for("awready");
        @(negedge clk);
        awvalid = 1'b0;
        // awready lasts a single cycle
        check_value("awready", 1'b0, awready);
        for (int i = 0; i <= len; i++) begin
            strb = strb_t'($urandom_range(15, 1));
            data = $urandom;
            wvalid = 1'b1;
            wdata = data;
            wstrb = strb;
            wid = id;
            wlast = (i == len);
            wait_for("wready");
            // a failing burst leaves the memory alone
            n = $countones(strb);
            if (exp_resp == RESP_OKAY)
                n = model_write(beat_addr, data, strb);
            total += n;
            if (burst != BURST_FIXED)
                beat_addr += addr_t'(n);
            @(negedge clk);
        end
        wvalid = 1'b0;
        wlast = 1'b0;
        check_value("wready", 1'b0, wready);
        wait_for("bvalid");
        delay = $urandom % 4;
        repeat (delay) begin
            check_value("bvalid", 1'b1, bvalid);
            check_value("bid", id, bid);
            check_value("bresp", exp_resp, bresp);
            @(negedge clk);
        end
        check_value("bid", id, bid);
        check_value("bresp", exp_resp, bresp);
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        check_value("bvalid", 1'b0, bvalid);
    endtask

    task automatic do_read(input id_t id, input addr_t addr, input len_t len, input size_t size,
                           input burst_t burst, input resp_t exp_resp);
        addr_t beat_addr;
        data_t exp_data;
        int beats;
        int delay;
        beat_addr = addr;
        arvalid = 1'b1;
        arid = id;
        araddr = addr;
        arlen = len;
        arsize = size;
        arburst = burst;
        wait_for("arready");
        @(negedge clk);
        arvalid = 1'b0;
        check_value("arready", 1'b0, arready);
        // an error read ends after one zero beat
        beats = (exp_resp == RESP_OKAY) ? int'(len) + 1 : 1;
        for (int i = 0; i < beats; i++) begin
            exp_data = (exp_resp == RESP_OKAY) ? model_word(beat_addr, size) : '0;
            wait_for("rvalid");
            delay = $urandom % 4;
            for (int d = 0; d <= delay; d++) begin
                if (d > 0)
                    @(negedge clk);
                check_value("rvalid", 1'b1, rvalid);
                check_value("rdata", exp_data, rdata);
                check_value("rlast", (i == beats - 1), rlast);
                check_value("rid", id, rid);
                check_value("rresp", exp_resp, rresp);
            end
            rready = 1'b1;
            @(negedge clk);
            rready = 1'b0;
            if (burst != BURST_FIXED)
                beat_addr += addr_t'(1 << size);
        end
        check_value("rvalid", 1'b0, rvalid);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence

    initial begin
        id_t id;
        addr_t addr;
        len_t len;
        size_t size;
        int total;
        void'($urandom(32'h96e1));
        checks = 0;
        errors = 0;
        {awvalid, awid, awaddr, awlen, awsize, awburst} = '0;
        {wvalid, wdata, wid, wstrb, wlast, bready} = '0;
        {arvalid, arid, araddr, arlen, arsize, arburst, rready} = '0;
        for (int i = 0; i < MEM_BYTES; i++)
            model[i] = 8'(i);
        wait_for("resetn");
        @(negedge clk);

        // index pattern straight after reset
        repeat (8)
            do_read(id_t'($urandom), $urandom % MEM_BYTES, 4'd0, 3'd2, BURST_INCR, RESP_OKAY);

        // incr write then read back with burst code 2 acting as incr
        repeat (20) begin
            id = id_t'($urandom);
            addr = $urandom % MEM_BYTES;
            do_write(id, addr, len_t'($urandom), size_t'($urandom % 3),
                     burst_t'($urandom_range(2, 1)), RESP_OKAY, total);
            size = size_t'($urandom % 3);
            len = len_t'(((total - 1) >> size) > 15 ? 15 : (total - 1) >> size);
            do_read(id + 1'b1, addr, len, size, BURST_INCR, RESP_OKAY);
        end

        // fixed bursts stay on the start address
        repeat (6) begin
            id = id_t'($urandom);
            addr = $urandom % MEM_BYTES;
            do_write(id, addr, len_t'($urandom), 3'd2, BURST_FIXED, RESP_OKAY, total);
            do_read(id, addr, len_t'($urandom), size_t'($urandom % 3), BURST_FIXED, RESP_OKAY);
        end

        // out of range start followed by oversized beats
        repeat (4) begin
            addr = MEM_BYTES + ($urandom % 4096);
            do_write(id_t'($urandom), addr, len_t'($urandom), size_t'($urandom),
                     BURST_INCR, RESP_SLVERR, total);
            do_read(id_t'($urandom), addr, len_t'($urandom), size_t'($urandom),
                    BURST_INCR, RESP_SLVERR);
            addr = $urandom % MEM_BYTES;
            do_write(id_t'($urandom), addr, len_t'($urandom), size_t'($urandom_range(7, 3)),
                     BURST_INCR, RESP_DECERR, total);
            do_read(id_t'($urandom), addr, len_t'($urandom), size_t'($urandom_range(7, 3)),
                    BURST_FIXED, RESP_DECERR);
        end

        // sweep the whole memory against the model
        do_read(4'd1, 32'd0, 4'd15, 3'd2, BURST_INCR, RESP_OKAY);
        do_read(4'd2, 32'd64, 4'd15, 3'd2, BURST_INCR, RESP_OKAY);

        $display("checks: %0d, errors: %0d, timeouts: 0", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- flist.f
design/axi_bus_pkg.sv
design/slave_state_pkg.sv
design/slave_ifs.sv
design/burst_ctrl.sv
design/beat_addr_gen.sv
design/byte_mem.sv
design/axi_mem_slave.sv
bench/tb_clk_gen.sv
bench/tb_axi_mem_slave.sv

//--- Bender.yml
package:
  name: axi_mem_slave

sources:
  - design/axi_bus_pkg.sv
  - design/slave_state_pkg.sv
  - design/slave_ifs.sv
  - design/burst_ctrl.sv
  - design/beat_addr_gen.sv
  - design/byte_mem.sv
  - design/axi_mem_slave.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_axi_mem_slave.sv
